// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ************************************************************
    // Memory bus
    // ************************************************************

    // Request from the master; any wstrb bit set marks a write
    typedef struct packed {
        logic        mem_valid;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
        logic [3:0]  mem_wstrb;
    } mem_in_type;

    typedef struct packed {
        logic        mem_ready;
        logic [31:0] mem_rdata;
        logic        mem_error;
    } mem_out_type;

    // ************************************************************
    // Receiver
    // ************************************************************

    // One pulse per received frame
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       frame_error;
    } rx_event_type;

    // Register map
    localparam logic [31:0] addr_tx_data = 32'd0;
    localparam logic [31:0] addr_rx_data = 32'd4;
    localparam logic [31:0] addr_status = 32'd8;

    localparam logic [31:0] default_clocks_per_bit = 32'd16;

endpackage

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int unsigned clocks_per_bit = uart_pkg::default_clocks_per_bit
) (
    input wire clock,
    input wire reset,
    input wire uart_pkg::mem_in_type uart_in,
    output uart_pkg::mem_out_type uart_out,
    output logic tx,
    output logic busy
);

    // State 0 is idle, states 1 to 10 hold the start, data and stop bits
    typedef struct packed {
        logic [3:0]  state;
        logic [9:0]  data;
        logic [31:0] counter;
        logic        ready;
    } register_type;

    register_type r;
    register_type rin;

    always_comb begin
        rin = r;
        rin.counter = r.counter + 32'd1;
        rin.ready = 1'b0;

        case (r.state)
            4'd0: begin
                rin.counter = 32'd0;
                if (uart_in.mem_valid && |uart_in.mem_wstrb) begin
                    rin.data = {1'b1, uart_in.mem_wdata[7:0], 1'b0};
                    rin.state = 4'd1;
                end
            end
            4'd10: begin
                // End of the stop bit releases the stalled write
                if (r.counter == clocks_per_bit - 1) begin
                    rin.counter = 32'd0;
                    rin.state = 4'd0;
                    rin.ready = 1'b1;
                end
            end
            default: begin
                if (r.counter == clocks_per_bit - 1) begin
                    rin.data = {1'b1, r.data[9:1]};
                    rin.state = r.state + 4'd1;
                    rin.counter = 32'd0;
                end
            end
        endcase
    end

    assign uart_out.mem_ready = r.ready;
    assign uart_out.mem_rdata = 32'd0;
    assign uart_out.mem_error = 1'b0;

    assign tx = r.data[0];
    assign busy = (r.state != 4'd0) || r.ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            r.state <= 4'd0;
            r.data <= 10'h3ff;
            r.counter <= 32'd0;
            r.ready <= 1'b0;
        end else begin
            r <= rin;
        end
    end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int unsigned clocks_per_bit = uart_pkg::default_clocks_per_bit
) (
    input wire clock,
    input wire reset,
    input wire rx,
    output uart_pkg::rx_event_type rx_event
);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_type;

    typedef struct packed {
        state_type              state;
        logic [31:0]            counter;
        logic [2:0]             index;
        logic [7:0]             shift;
        uart_pkg::rx_event_type rx_out;
    } register_type;

    register_type r;
    register_type rin;

    // Bit 0 and 1 form the synchronizer, bit 2 is kept for edge detection
    logic [2:0] rx_pipe;
    logic rx_sync;
    logic rx_prev;

    assign rx_sync = rx_pipe[1];
    assign rx_prev = rx_pipe[2];

    always_ff @(posedge clock) begin
        if (!reset) begin
            rx_pipe <= 3'b111;
        end else begin
            rx_pipe <= {rx_pipe[1:0], rx};
        end
    end

    // ************************************************************
    // Frame FSM
    // ************************************************************

    always_comb begin
        rin = r;
        rin.counter = r.counter + 32'd1;
        rin.rx_out.valid = 1'b0;

        case (r.state)
            s_idle: begin
                rin.counter = 32'd0;
                if (rx_prev && !rx_sync) begin
                    rin.state = s_start;
                end
            end
            s_start: begin
                // A line that is high again at mid-bit was a glitch
                if (r.counter == clocks_per_bit / 2 - 1) begin
                    rin.counter = 32'd0;
                    rin.index = 3'd0;
                    rin.state = rx_sync ? s_idle : s_data;
                end
            end
            s_data: begin
                if (r.counter == clocks_per_bit - 1) begin
                    rin.counter = 32'd0;
                    rin.shift = {rx_sync, r.shift[7:1]};
                    rin.index = r.index + 3'd1;
                    if (r.index == 3'd7) begin
                        rin.state = s_stop;
                    end
                end
            end
            default: begin
                if (r.counter == clocks_per_bit - 1) begin
                    rin.counter = 32'd0;
                    rin.state = s_idle;
                    rin.rx_out.valid = 1'b1;
                    rin.rx_out.data = r.shift;
                    rin.rx_out.frame_error = !rx_sync;
                end
            end
        endcase
    end

    assign rx_event = r.rx_out;

    always_ff @(posedge clock) begin
        if (!reset) begin
            r <= '0;
        end else begin
            r <= rin;
        end
    end

endmodule

`default_nettype wire

// File: source/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input wire clock,
    input wire reset,
    input wire uart_pkg::mem_in_type bus_in,
    output uart_pkg::mem_out_type bus_out,
    output uart_pkg::mem_in_type tx_req,
    input wire uart_pkg::mem_out_type tx_rsp,
    input wire tx_busy,
    input wire uart_pkg::rx_event_type rx_event
);

    uart_pkg::mem_out_type local_rsp;
    uart_pkg::mem_out_type local_rsp_next;
    logic is_read;
    logic tx_write;
    logic local_accept;
    logic rd_rx_data;
    logic rd_status;
    logic [7:0] rx_byte;
    logic rx_valid;
    logic overrun;
    logic frame_error;
    logic [31:0] status_word;

    assign is_read = ~|bus_in.mem_wstrb;
    assign tx_write = bus_in.mem_valid && !is_read && bus_in.mem_addr == uart_pkg::addr_tx_data;

    // The request is still held during its ready cycle, so it must not be taken twice
    assign local_accept = bus_in.mem_valid && !tx_write && !local_rsp.mem_ready;

    assign bus_out = tx_rsp.mem_ready ? tx_rsp : local_rsp;

    always_comb begin
        tx_req = bus_in;
        tx_req.mem_valid = tx_write && !bus_out.mem_ready;
    end

    assign status_word = {28'd0, frame_error, overrun, tx_busy, rx_valid};

    // ************************************************************
    // Address decode
    // ************************************************************

    always_comb begin
        local_rsp_next = '0;
        rd_rx_data = 1'b0;
        rd_status = 1'b0;
        if (local_accept) begin
            local_rsp_next.mem_ready = 1'b1;
            case (bus_in.mem_addr)
                uart_pkg::addr_tx_data: begin
                    // Reading the transmit register gives zero
                    local_rsp_next.mem_rdata = 32'd0;
                end
                uart_pkg::addr_rx_data: begin
                    rd_rx_data = is_read;
                    local_rsp_next.mem_rdata = is_read ? {24'd0, rx_byte} : 32'd0;
                end
                uart_pkg::addr_status: begin
                    rd_status = is_read;
                    local_rsp_next.mem_rdata = is_read ? status_word : 32'd0;
                end
                default: begin
                    local_rsp_next.mem_error = 1'b1;
                end
            endcase
        end
    end

    // A new frame wins over a clear in the same cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            local_rsp <= '0;
            rx_valid <= 1'b0;
            overrun <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            local_rsp <= local_rsp_next;
            rx_valid <= rx_event.valid || (rx_valid && !rd_rx_data);
            overrun <= (rx_event.valid && rx_valid && !rd_rx_data) || (overrun && !rd_status);
            frame_error <= (rx_event.valid && rx_event.frame_error)
                || (frame_error && !rd_status);
        end
    end

    always_ff @(posedge clock) begin
        if (rx_event.valid) begin
            rx_byte <= rx_event.data;
        end
    end

endmodule

`default_nettype wire

// File: source/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int unsigned clocks_per_bit = uart_pkg::default_clocks_per_bit
) (
    input wire clock,
    input wire reset,
    input wire uart_pkg::mem_in_type bus_in,
    output wire uart_pkg::mem_out_type bus_out,
    output wire tx,
    input wire rx
);

    wire uart_pkg::mem_in_type tx_req;
    wire uart_pkg::mem_out_type tx_rsp;
    wire tx_busy;
    wire uart_pkg::rx_event_type rx_event;

    uart_regs regs (
        .clock(clock),
        .reset(reset),
        .bus_in(bus_in),
        .bus_out(bus_out),
        .tx_req(tx_req),
        .tx_rsp(tx_rsp),
        .tx_busy(tx_busy),
        .rx_event(rx_event)
    );

    uart_tx #(
        .clocks_per_bit(clocks_per_bit)
    ) transmitter (
        .clock(clock),
        .reset(reset),
        .uart_in(tx_req),
        .uart_out(tx_rsp),
        .tx(tx),
        .busy(tx_busy)
    );

    uart_rx #(
        .clocks_per_bit(clocks_per_bit)
    ) receiver (
        .clock(clock),
        .reset(reset),
        .rx(rx),
        .rx_event(rx_event)
    );

endmodule

`default_nettype wire

// File: sim/uart_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_checker #(
    parameter int unsigned clocks_per_bit = uart_pkg::default_clocks_per_bit
) (
    input wire clock,
    input wire reset,
    input wire uart_pkg::mem_in_type bus_in,
    input wire uart_pkg::mem_out_type bus_out,
    input wire tx,
    input wire uart_pkg::rx_event_type rx_event,
    input wire check_enable,
    input wire [31:0] check_rdata,
    input wire check_error,
    output int mismatch_count,
    output int rx_count
);

    logic [7:0] last_tx_byte;
    logic [9:0] sampled;
    logic tx_write;
    int frames_started;
    int writes_done;
    int frame_errors;
    int bus_errors;

    assign tx_write = bus_in.mem_valid && |bus_in.mem_wstrb
        && bus_in.mem_addr == uart_pkg::addr_tx_data;
    assign mismatch_count = frame_errors + bus_errors;

    // Start bit first, then data LSB first, then the stop bit
    function automatic logic [9:0] expected_frame(input logic [7:0] value);
        logic [9:0] bits;
        bits[0] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            bits[i + 1] = value[i];
        end
        bits[9] = 1'b1;
        return bits;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] expected,
        input logic [31:0] got);
        $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, expected, got);
    endtask

    // ************************************************************
    // Frame decoder on tx
    // ************************************************************

    // The first low tx at a falling edge is half a clock into the start bit
    always @(negedge clock) begin
        if (reset && !tx) begin
            if (!tx_write || frames_started != writes_done) begin
                $display("ERROR at %0t: a frame started on tx without a new transmit write",
                    $time);
                frame_errors++;
            end
            frames_started++;
            repeat (clocks_per_bit / 2 - 1) @(negedge clock);
            sampled[0] = tx;
            for (int i = 1; i < 10; i++) begin
                repeat (clocks_per_bit) @(negedge clock);
                sampled[i] = tx;
            end
            if (sampled !== expected_frame(last_tx_byte)) begin
                show_mismatch("tx frame", {22'd0, expected_frame(last_tx_byte)},
                    {22'd0, sampled});
                frame_errors++;
            end
        end
    end

    // ************************************************************
    // Bus monitor
    // ************************************************************

    always @(negedge clock) begin
        if (!reset) begin
            if (tx !== 1'b1 || bus_out.mem_ready !== 1'b0) begin
                $display("ERROR at %0t: in reset tx is %b and mem_ready is %b", $time, tx,
                    bus_out.mem_ready);
                bus_errors++;
            end
        end else begin
            if (tx_write) begin
                last_tx_byte = bus_in.mem_wdata[7:0];
            end
            if (rx_event.valid) begin
                rx_count++;
            end
            if (bus_out.mem_ready) begin
                if (!bus_in.mem_valid) begin
                    $display("ERROR at %0t: mem_ready is high without a request", $time);
                    bus_errors++;
                end
                if (check_enable && bus_out.mem_rdata !== check_rdata) begin
                    show_mismatch("bus_out.mem_rdata", check_rdata, bus_out.mem_rdata);
                    bus_errors++;
                end
                if (check_enable && bus_out.mem_error !== check_error) begin
                    show_mismatch("bus_out.mem_error", {31'd0, check_error},
                        {31'd0, bus_out.mem_error});
                    bus_errors++;
                end
                if (tx_write) begin
                    if (frames_started != writes_done + 1) begin
                        $display("ERROR at %0t: a transmit write ended without one frame on tx",
                            $time);
                        bus_errors++;
                    end
                    writes_done++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    localparam int unsigned clocks_per_bit = 8;
    localparam int bus_timeout = 200;

    logic clock = 1'b0;
    logic reset;
    uart_pkg::mem_in_type bus_in;
    wire uart_pkg::mem_out_type bus_out;
    wire tx;
    wire rx;
    logic serial_line;
    logic loopback;
    logic check_enable;
    logic [31:0] check_rdata;
    logic check_error;
    int mismatch_count;
    int rx_count;
    int timeout_count;
    int target;
    logic [31:0] lcg_state;
    logic [31:0] read_value;
    logic [7:0] sent_byte;
    logic [7:0] first_byte;

    assign rx = loopback ? tx : serial_line;

    uart_top #(
        .clocks_per_bit(clocks_per_bit)
    ) uut (
        .clock(clock),
        .reset(reset),
        .bus_in(bus_in),
        .bus_out(bus_out),
        .tx(tx),
        .rx(rx)
    );

    uart_checker #(
        .clocks_per_bit(clocks_per_bit)
    ) monitor (
        .clock(clock),
        .reset(reset),
        .bus_in(bus_in),
        .bus_out(bus_out),
        .tx(tx),
        .rx_event(uut.rx_event),
        .check_enable(check_enable),
        .check_rdata(check_rdata),
        .check_error(check_error),
        .mismatch_count(mismatch_count),
        .rx_count(rx_count)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bus tasks start and end 1 ns after a rising edge
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
        input logic [3:0] wstrb, input logic check, input logic [31:0] exp_rdata,
        input logic exp_error, output logic [31:0] rdata);
        int cycles;
        bus_in.mem_valid = 1'b1;
        bus_in.mem_addr = addr;
        bus_in.mem_wdata = wdata;
        bus_in.mem_wstrb = wstrb;
        check_enable = check;
        check_rdata = exp_rdata;
        check_error = exp_error;
        rdata = 32'd0;
        cycles = 0;
        @(negedge clock);
        while (!bus_out.mem_ready && cycles < bus_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (bus_out.mem_ready) begin
            rdata = bus_out.mem_rdata;
        end else begin
            $display("ERROR at %0t: no mem_ready within %0d cycles for address %0d", $time,
                bus_timeout, addr);
            timeout_count++;
        end
        @(posedge clock);
        #1;
        bus_in = '0;
        check_enable = 1'b0;
    endtask

    task automatic write_tx(input logic [7:0] value);
        logic [31:0] ignored;
        bus_access(uart_pkg::addr_tx_data, {24'd0, value}, 4'hf, 1'b1, 32'd0, 1'b0, ignored);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] expected,
        input logic exp_error);
        bus_access(addr, 32'd0, 4'h0, 1'b1, expected, exp_error, read_value);
    endtask

    task automatic poll_rx_valid();
        int polls;
        polls = 0;
        read_value = 32'd0;
        while (!read_value[0] && polls < 100) begin
            bus_access(uart_pkg::addr_status, 32'd0, 4'h0, 1'b0, 32'd0, 1'b0, read_value);
            polls++;
        end
        if (!read_value[0]) begin
            $display("ERROR at %0t: rx_valid still clear after %0d status reads", $time, polls);
            timeout_count++;
        end
    endtask

    task automatic wait_rx_count(input int goal);
        int cycles;
        cycles = 0;
        while (rx_count < goal && cycles < 40 * clocks_per_bit) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (rx_count < goal) begin
            $display("ERROR at %0t: the receiver did not finish the expected frames", $time);
            timeout_count++;
        end
    endtask

    task automatic send_serial(input logic [7:0] value, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            serial_line = bits[i];
            repeat (clocks_per_bit) begin
                @(posedge clock);
                #1;
            end
        end
        serial_line = 1'b1;
    endtask

    // ************************************************************
    // Stimulus
    // ************************************************************

    initial begin
        reset = 1'b0;
        bus_in = '0;
        serial_line = 1'b1;
        loopback = 1'b0;
        check_enable = 1'b0;
        check_rdata = 32'd0;
        check_error = 1'b0;
        timeout_count = 0;
        target = 0;
        lcg_state = 32'ha17c7137;
        read_value = 32'd0;
        sent_byte = 8'd0;
        first_byte = 8'd0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;

        read_check(uart_pkg::addr_status, 32'd0, 1'b0);

        // Status between frames must show the transmitter idle
        for (int i = 0; i < 20; i++) begin
            lcg_state = lcg_next(lcg_state);
            write_tx(lcg_state[23:16]);
            read_check(uart_pkg::addr_status, 32'd0, 1'b0);
        end

        loopback = 1'b1;
        lcg_state = lcg_next(lcg_state);
        sent_byte = lcg_state[23:16];
        write_tx(sent_byte);
        poll_rx_valid();
        read_check(uart_pkg::addr_rx_data, {24'd0, sent_byte}, 1'b0);
        read_check(uart_pkg::addr_status, 32'd0, 1'b0);

        // Second byte lands on an unread first byte
        target = rx_count + 2;
        lcg_state = lcg_next(lcg_state);
        first_byte = lcg_state[23:16];
        lcg_state = lcg_next(lcg_state);
        sent_byte = lcg_state[23:16];
        write_tx(first_byte);
        write_tx(sent_byte);
        wait_rx_count(target);
        read_check(uart_pkg::addr_status, 32'h5, 1'b0);
        read_check(uart_pkg::addr_rx_data, {24'd0, sent_byte}, 1'b0);
        read_check(uart_pkg::addr_status, 32'd0, 1'b0);

        loopback = 1'b0;
        target = rx_count + 1;
        lcg_state = lcg_next(lcg_state);
        sent_byte = lcg_state[23:16];
        send_serial(sent_byte, 1'b0);
        wait_rx_count(target);
        read_check(uart_pkg::addr_status, 32'h9, 1'b0);
        read_check(uart_pkg::addr_status, 32'h1, 1'b0);
        read_check(uart_pkg::addr_rx_data, {24'd0, sent_byte}, 1'b0);

        read_check(32'd12, 32'd0, 1'b1);

        $display("Closing counts: mismatches=%0d timeouts=%0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_top.sv
sim/uart_checker.sv
sim/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --timing --timescale 1ns/1ps
TOP ?= uart_tb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
